//--- sim.f
+incdir+.
aud_pkg.sv
aud_ram_if.sv
aud_ctrl.sv
aud_recorder.sv
aud_player.sv
aud_sample_ram.sv
aud_top.sv
tb_aud_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_aud_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_aud_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "aud_config.svh"

module tb_aud_top;
    import aud_pkg::*;

    localparam int HALF = 20;                          // bclk cycles per half frame
    localparam int WORDS = 8 + 8 + 8 + 64;             // recorded plus played words
    localparam int LIMIT = WORDS * 40 * 2 * HALF + 200;

    logic                   bclk;
    logic                   rst_n;
    logic                   lrck;
    logic                   adcdat;
    logic                   cmd_stb;
    aud_cmd_e               cmd;
    logic                   dacdat;
    aud_mode_e              mode;
    logic [`AUD_ADDR_W:0]   rec_len;
    logic [`AUD_ADDR_W-1:0] addr;

    logic [4:0]             hc;          // position inside the half frame
    logic [`AUD_WORD_W-1:0] cur_w;
    logic [`AUD_WORD_W-1:0] left_w;      // next left word
    logic [`AUD_WORD_W-1:0] rec_q[$];   // left words expected in the RAM
    logic                   rec_on;
    integer                 seed;
    int                     errors;
    int                     cyc;

    aud_top u_dut (
        .i_bclk    (bclk),
        .i_rst_n   (rst_n),
        .i_lrck    (lrck),
        .i_adcdat  (adcdat),
        .i_cmd_stb (cmd_stb),
        .i_cmd     (cmd),
        .o_dacdat  (dacdat),
        .o_mode    (mode),
        .o_rec_len (rec_len),
        .o_addr    (addr)
    );

    initial begin
        bclk = 1'b0;
        forever #20 bclk = ~bclk;
    end

    // bit in slot k of a half frame
    // MSB sits AUD_DATA_DLY slots after the edge
    function automatic logic slot_bit(input logic [`AUD_WORD_W-1:0] w, input int k);
        if (k >= `AUD_DATA_DLY && k < `AUD_DATA_DLY + `AUD_WORD_W) begin
            return w[`AUD_WORD_W - 1 - (k - `AUD_DATA_DLY)];
        end
        return 1'b0;
    endfunction

    // codec model for the frame clock and ADC line
    always @(negedge bclk) begin
        if (hc == 5'(HALF - 1)) begin
            hc     <= '0;
            lrck   <= ~lrck;
            adcdat <= 1'b0;
            if (lrck) begin
                if (rec_on && rec_q.size() < 64) begin
                    rec_q.push_back(left_w);
                end
                cur_w  <= left_w;
                left_w <= 16'($random(seed));
            end else begin
                cur_w <= 16'($random(seed)); // right channel is ignored by the DUT
            end
        end else begin
            hc     <= hc + 1'b1;
            adcdat <= slot_bit(cur_w, int'(hc) + 1);
        end
    end

    always @(posedge bclk) begin
        cyc <= cyc + 1;
        if (cyc >= LIMIT) begin
            $display("timeout after %0d cycles, DUT stopped responding", cyc);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    a_rst_vals: assert property (@(posedge bclk)
        !rst_n |-> (dacdat == 1'b0 && mode == MODE_IDLE && rec_len == '0 && addr == '0))
        else begin
            errors++;
            $display("outputs not at reset values during reset");
        end

    a_quiet: assert property (@(posedge bclk) (mode != MODE_PLAY) |-> !dacdat)
        else begin
            errors++;
            $display("DAC line active outside play mode");
        end

    task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] got);
        assert (exp == got) else begin
            errors++;
            $display("ERR %s exp %h got %h", name, exp, got);
        end
    endtask

    // waits for the falling edge that opens the half selected by lr
    task automatic sync_half(input logic lr);
        do begin
            @(negedge bclk);
        end while (!(hc == 5'(HALF - 1) && lrck == ~lr));
    endtask

    task automatic send_cmd(input aud_cmd_e c);
        cmd     <= c;
        cmd_stb <= 1'b1;
        @(negedge bclk);
        cmd_stb <= 1'b0;
    endtask

    // called on the edge that opens a left half
    task automatic check_frame(input logic [`AUD_WORD_W-1:0] w);
        for (int n = 0; n < 2 * HALF; n++) begin
            if (n > 0) begin
                @(negedge bclk);
            end
            compare("o_dacdat", 16'(slot_bit(w, n % HALF)), 16'(dacdat));
        end
    endtask

    task automatic play_words(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            sync_half(1'b0);
            check_frame(rec_q[i]);
        end
        sync_half(1'b0);
        @(negedge bclk);
        compare("o_mode", 16'(MODE_IDLE), 16'(mode)); // idle at the frame boundary
        for (int n = 0; n < 2 * HALF; n++) begin
            @(negedge bclk);
            compare("o_dacdat", 16'h0, 16'(dacdat));
        end
    endtask

    initial begin
        seed    = 95733;
        left_w  = 16'($random(seed));
        errors  = 0;
        cyc     = 0;
        rst_n   = 1'b0;
        lrck    = 1'b0;
        adcdat  = 1'b0;
        cmd_stb = 1'b0;
        cmd     = CMD_STOP;
        hc      = '0;
        cur_w   = '0;
        rec_on  = 1'b0;
        repeat (10) @(negedge bclk);
        rst_n <= 1'b1;
        @(negedge bclk);
        compare("o_mode", 16'(MODE_IDLE), 16'(mode));
        compare("o_rec_len", 16'h0, 16'(rec_len));
        compare("o_addr", 16'h0, 16'(addr));
        compare("o_dacdat", 16'h0, 16'(dacdat));

        // record eight left words
        sync_half(1'b1);
        rec_q.delete();
        rec_on = 1'b1;
        send_cmd(CMD_REC);
        for (int i = 0; i < 8; i++) begin
            sync_half(1'b1);
            compare("o_rec_len", 16'(rec_q.size()), 16'(rec_len));
        end
        rec_on = 1'b0;
        send_cmd(CMD_STOP);
        @(negedge bclk);
        compare("o_rec_len", 16'd8, 16'(rec_len));
        compare("o_mode", 16'(MODE_IDLE), 16'(mode));

        // full playback
        sync_half(1'b1);
        send_cmd(CMD_PLAY);
        play_words(0, 7);

        // pause inside the fourth word and resume
        sync_half(1'b1);
        send_cmd(CMD_PLAY);
        for (int i = 0; i < 3; i++) begin
            sync_half(1'b0);
            check_frame(rec_q[i]);
        end
        sync_half(1'b0);
        repeat (4) @(negedge bclk);
        send_cmd(CMD_PAUSE);
        for (int n = 0; n < 2 * HALF; n++) begin
            @(negedge bclk);
            compare("o_mode", 16'(MODE_PAUSE), 16'(mode));
            compare("o_addr", 16'd3, 16'(addr));
            compare("o_dacdat", 16'h0, 16'(dacdat));
        end
        sync_half(1'b1);
        send_cmd(CMD_PLAY);
        play_words(3, 7);

        // record until the memory is full
        sync_half(1'b1);
        rec_q.delete();
        rec_on = 1'b1;
        send_cmd(CMD_REC);
        for (int f = 0; f < 70 && mode != MODE_IDLE; f++) begin
            sync_half(1'b1);
        end
        rec_on = 1'b0;
        compare("o_mode", 16'(MODE_IDLE), 16'(mode));
        compare("o_rec_len", 16'd64, 16'(rec_len));

        repeat (5) @(negedge bclk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- aud_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "aud_config.svh"

module aud_top (
    input  logic                   i_bclk,
    input  logic                   i_rst_n,
    input  logic                   i_lrck,
    input  logic                   i_adcdat,
    input  logic                   i_cmd_stb,
    input  aud_pkg::aud_cmd_e      i_cmd,
    output logic                   o_dacdat,
    output aud_pkg::aud_mode_e     o_mode,
    output logic [`AUD_ADDR_W:0]   o_rec_len,
    output logic [`AUD_ADDR_W-1:0] o_addr
);
    logic [`AUD_WORD_W-1:0] rec_word;
    logic                   rec_stb;
    logic [`AUD_WORD_W-1:0] play_word;
    logic                   play_load;
    logic                   play_req;

    aud_ram_if ram_if ();

    aud_ctrl u_ctrl (
        .i_bclk      (i_bclk),
        .i_rst_n     (i_rst_n),
        .i_cmd_stb   (i_cmd_stb),
        .i_cmd       (i_cmd),
        .i_rec_word  (rec_word),
        .i_rec_stb   (rec_stb),
        .i_play_req  (play_req),
        .i_lrck      (i_lrck),
        .o_mode      (o_mode),
        .o_play_word (play_word),
        .o_play_load (play_load),
        .o_rec_len   (o_rec_len),
        .o_addr      (o_addr),
        .ram         (ram_if.ctrl)
    );

    aud_recorder u_recorder (
        .i_bclk     (i_bclk),
        .i_rst_n    (i_rst_n),
        .i_lrck     (i_lrck),
        .i_adcdat   (i_adcdat),
        .i_mode     (o_mode),
        .o_word     (rec_word),
        .o_word_stb (rec_stb)
    );

    aud_player u_player (
        .i_bclk      (i_bclk),
        .i_rst_n     (i_rst_n),
        .i_lrck      (i_lrck),
        .i_mode      (o_mode),
        .i_word      (play_word),
        .i_word_load (play_load),
        .o_word_req  (play_req),
        .o_dacdat    (o_dacdat)
    );

    aud_sample_ram u_ram (
        .i_bclk  (i_bclk),
        .i_rst_n (i_rst_n),
        .ram     (ram_if.mem)
    );

endmodule

`default_nettype wire

//--- aud_sample_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "aud_config.svh"

module aud_sample_ram (
    input  logic    i_bclk,
    input  logic    i_rst_n,
    aud_ram_if.mem  ram
);
    localparam int DEPTH = 1 << `AUD_ADDR_W;

    logic [`AUD_WORD_W-1:0] mem [DEPTH];
    logic [`AUD_WORD_W-1:0] rdata_q;

    assign ram.rdata = rdata_q;

    always_ff @(posedge i_bclk) begin
        if (ram.we) begin
            mem[ram.addr] <= ram.wdata;
        end
    end

    // registered read, holds between reads
    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rdata_q <= '0;
        end else if (ram.re) begin
            rdata_q <= mem[ram.addr];
        end
    end

endmodule

`default_nettype wire

//--- aud_player.sv
`timescale 1ns/1ps
`default_nettype none

`include "aud_config.svh"

module aud_player (
    input  logic                   i_bclk,
    input  logic                   i_rst_n,
    input  logic                   i_lrck,
    input  aud_pkg::aud_mode_e     i_mode,
    input  logic [`AUD_WORD_W-1:0] i_word,
    input  logic                   i_word_load,
    output logic                   o_word_req,
    output logic                   o_dacdat
);
    import aud_pkg::*;

    localparam logic [4:0] SLOT_LO = 5'(`AUD_DATA_DLY);
    localparam logic [4:0] SLOT_HI = 5'(`AUD_DATA_DLY + `AUD_WORD_W);

    logic                   lrck_q;
    logic                   edge_det;
    logic                   fall_det;
    logic                   play;
    logic                   play_q;
    logic                   start;
    logic [4:0]             cnt_q;
    logic [4:0]             cnt_nxt;
    logic [`AUD_WORD_W-1:0] nxt_word_q;  // prefetched
    logic [`AUD_WORD_W-1:0] cur_word_q;  // sent in both halves
    logic [`AUD_WORD_W-1:0] cur_nxt;
    logic [`AUD_WORD_W-1:0] tx_q;
    logic [`AUD_WORD_W-1:0] tx_nxt;
    logic                   nxt_vld_q;
    logic                   send_q;
    logic                   send_nxt;
    logic                   dac_q;

    function automatic logic in_slot(input logic [4:0] c);
        return (c >= SLOT_LO) && (c < SLOT_HI);
    endfunction

    assign play     = (i_mode == MODE_PLAY);
    assign edge_det = lrck_q ^ i_lrck;
    assign fall_det = lrck_q & ~i_lrck;
    assign start    = play && fall_det && nxt_vld_q;
    assign o_dacdat = dac_q & play; // silent at once on pause or stop

    always_comb begin
        cnt_nxt = cnt_q;
        if (edge_det) begin
            cnt_nxt = 5'd1;
        end else if (cnt_q != '1) begin
            cnt_nxt = cnt_q + 1'b1;
        end

        send_nxt = send_q;
        cur_nxt  = cur_word_q;
        if (!play) begin
            send_nxt = 1'b0;
        end else if (fall_det) begin
            send_nxt = nxt_vld_q; // no word loaded means a silent frame
            cur_nxt  = nxt_word_q;
        end

        tx_nxt = tx_q;
        if (edge_det) begin
            tx_nxt = cur_nxt; // reload for each half
        end else if (in_slot(cnt_q)) begin
            tx_nxt = {tx_q[`AUD_WORD_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lrck_q     <= 1'b0;
            cnt_q      <= '1;
            play_q     <= 1'b0;
            nxt_vld_q  <= 1'b0;
            send_q     <= 1'b0;
            dac_q      <= 1'b0;
            o_word_req <= 1'b0;
        end else begin
            lrck_q <= i_lrck;
            cnt_q  <= cnt_nxt;
            play_q <= play;
            send_q <= send_nxt;
            dac_q  <= send_nxt && in_slot(cnt_nxt) && tx_nxt[`AUD_WORD_W-1];

            // on entering play, then prefetch as each word goes out
            o_word_req <= play && (!play_q || start);

            if (!play) begin
                nxt_vld_q <= 1'b0; // latched word is dropped
            end else if (i_word_load) begin
                nxt_vld_q <= 1'b1;
            end else if (fall_det) begin
                nxt_vld_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_bclk) begin
        if (i_word_load) begin
            nxt_word_q <= i_word;
        end
        cur_word_q <= cur_nxt;
        tx_q       <= tx_nxt;
    end

    // line stays quiet from the cycle after play mode is left
    a_quiet: assert property (@(posedge i_bclk) disable iff (!i_rst_n)
        !play |=> !dac_q);

endmodule

`default_nettype wire

//--- aud_recorder.sv
`timescale 1ns/1ps
`default_nettype none

`include "aud_config.svh"

module aud_recorder (
    input  logic                   i_bclk,
    input  logic                   i_rst_n,
    input  logic                   i_lrck,
    input  logic                   i_adcdat,
    input  aud_pkg::aud_mode_e     i_mode,
    output logic [`AUD_WORD_W-1:0] o_word,
    output logic                   o_word_stb
);
    import aud_pkg::*;

    // bit positions counted from the frame-clock edge
    localparam logic [4:0] SLOT_LO = 5'(`AUD_DATA_DLY);
    localparam logic [4:0] SLOT_HI = 5'(`AUD_DATA_DLY + `AUD_WORD_W);

    logic                   lrck_q;
    logic                   edge_det;
    logic                   fall_det;
    logic [4:0]             cnt_q;
    logic                   armed_q;  // inside a left half that began in record mode
    logic                   rec;
    logic                   take_bit;
    logic                   last_bit;
    logic [`AUD_WORD_W-1:0] shift_q;

    assign rec      = (i_mode == MODE_REC);
    assign edge_det = lrck_q ^ i_lrck;
    assign fall_det = lrck_q & ~i_lrck;

    assign take_bit = armed_q && rec && (cnt_q >= SLOT_LO) && (cnt_q < SLOT_HI);
    assign last_bit = take_bit && (cnt_q == SLOT_HI - 1'b1);
    assign o_word   = shift_q;

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lrck_q     <= 1'b0;
            cnt_q      <= '1;
            armed_q    <= 1'b0;
            o_word_stb <= 1'b0;
        end else begin
            lrck_q <= i_lrck;

            if (edge_det) begin
                cnt_q <= 5'd1;
            end else if (cnt_q != '1) begin
                cnt_q <= cnt_q + 1'b1; // saturate past the slots
            end

            if (!rec) begin
                armed_q <= 1'b0;
            end else if (fall_det) begin
                armed_q <= 1'b1;
            end else if (edge_det) begin
                armed_q <= 1'b0; // right half is skipped
            end

            o_word_stb <= last_bit;
        end
    end

    // MSB first
    always_ff @(posedge i_bclk) begin
        if (take_bit) begin
            shift_q <= {shift_q[`AUD_WORD_W-2:0], i_adcdat};
        end
    end

    // a strobe only closes a word taken entirely from the left half
    a_stb_left: assert property (@(posedge i_bclk) disable iff (!i_rst_n)
        o_word_stb |-> !$past(i_lrck) && !$past(i_lrck, `AUD_DATA_DLY + `AUD_WORD_W));

endmodule

`default_nettype wire

//--- aud_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "aud_config.svh"

module aud_ctrl (
    input  logic                   i_bclk,
    input  logic                   i_rst_n,
    input  logic                   i_cmd_stb,
    input  aud_pkg::aud_cmd_e      i_cmd,
    input  logic [`AUD_WORD_W-1:0] i_rec_word,
    input  logic                   i_rec_stb,
    input  logic                   i_play_req,
    input  logic                   i_lrck,
    output aud_pkg::aud_mode_e     o_mode,
    output logic [`AUD_WORD_W-1:0] o_play_word,
    output logic                   o_play_load,
    output logic [`AUD_ADDR_W:0]   o_rec_len,
    output logic [`AUD_ADDR_W-1:0] o_addr,
    aud_ram_if.ctrl                ram
);
    import aud_pkg::*;

    localparam logic [`AUD_ADDR_W:0] DEPTH = {1'b1, {`AUD_ADDR_W{1'b0}}};

    aud_mode_e              mode_q;
    logic [`AUD_ADDR_W:0]   rec_len_q;   // doubles as the record address
    logic [`AUD_ADDR_W-1:0] play_addr_q; // word currently on the DAC line
    logic [`AUD_ADDR_W:0]   rd_ptr;
    logic                   line_vld_q;  // a word has started on the line
    logic                   ld_pend_q;   // prefetched word waiting for its frame
    logic                   done_q;
    logic                   lrck_q;
    logic                   fall_det;
    logic                   wr_en;
    logic                   rd_en;

    assign fall_det = lrck_q & ~i_lrck;
    assign rd_ptr   = {1'b0, play_addr_q} + {{`AUD_ADDR_W{1'b0}}, line_vld_q};

    assign wr_en = i_rec_stb && (mode_q == MODE_REC);
    assign rd_en = i_play_req && (mode_q == MODE_PLAY) && !done_q && (rd_ptr < rec_len_q);

    assign ram.we    = wr_en;
    assign ram.re    = rd_en;
    assign ram.addr  = wr_en ? rec_len_q[`AUD_ADDR_W-1:0] : rd_ptr[`AUD_ADDR_W-1:0];
    assign ram.wdata = i_rec_word;

    assign o_play_word = ram.rdata;
    assign o_mode      = mode_q;
    assign o_rec_len   = rec_len_q;
    assign o_addr      = (mode_q == MODE_REC) ? rec_len_q[`AUD_ADDR_W-1:0] : play_addr_q;

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mode_q      <= MODE_IDLE;
            rec_len_q   <= '0;
            play_addr_q <= '0;
            line_vld_q  <= 1'b0;
            ld_pend_q   <= 1'b0;
            done_q      <= 1'b0;
            lrck_q      <= 1'b0;
            o_play_load <= 1'b0;
        end else begin
            lrck_q      <= i_lrck;
            o_play_load <= rd_en; // rdata valid now

            if (wr_en) begin
                rec_len_q <= rec_len_q + 1'b1;
                if (rec_len_q == DEPTH - 1'b1) begin
                    mode_q <= MODE_IDLE; // memory full
                end
            end

            // new frame retires the old word or ends after the last one
            if (mode_q == MODE_PLAY && fall_det) begin
                if (done_q) begin
                    mode_q     <= MODE_IDLE;
                    line_vld_q <= 1'b0;
                    done_q     <= 1'b0;
                end else if (ld_pend_q) begin
                    if (line_vld_q) begin
                        play_addr_q <= play_addr_q + 1'b1;
                    end
                    line_vld_q <= 1'b1;
                    ld_pend_q  <= 1'b0;
                end
            end

            if (o_play_load && mode_q == MODE_PLAY) begin
                ld_pend_q <= 1'b1;
            end

            if (i_play_req && mode_q == MODE_PLAY && !(rd_ptr < rec_len_q)) begin
                done_q <= 1'b1; // nothing left to fetch
            end

            if (i_cmd_stb) begin
                case (i_cmd)
                    CMD_REC: begin
                        if (mode_q == MODE_IDLE || mode_q == MODE_PAUSE) begin
                            mode_q      <= MODE_REC;
                            rec_len_q   <= '0;
                            play_addr_q <= '0;
                        end
                    end
                    CMD_PLAY: begin
                        if (mode_q == MODE_IDLE || mode_q == MODE_PAUSE) begin
                            mode_q <= MODE_PLAY;
                            if (mode_q == MODE_IDLE) begin
                                play_addr_q <= '0;
                            end
                            line_vld_q <= 1'b0; // resume from the frozen word
                            ld_pend_q  <= 1'b0;
                            done_q     <= 1'b0;
                        end
                    end
                    CMD_PAUSE: begin
                        if (mode_q == MODE_REC || mode_q == MODE_PLAY) begin
                            mode_q     <= MODE_PAUSE;
                            line_vld_q <= 1'b0;
                            ld_pend_q  <= 1'b0;
                            done_q     <= 1'b0;
                        end
                    end
                    CMD_STOP: begin
                        mode_q     <= MODE_IDLE;
                        line_vld_q <= 1'b0;
                        ld_pend_q  <= 1'b0;
                        done_q     <= 1'b0;
                    end
                endcase
            end
        end
    end

    // recorder strobes and player requests never collide on the single port
    a_rw_excl: assert property (@(posedge i_bclk) disable iff (!i_rst_n)
        !(ram.we && ram.re));

    // full-width pointer behind the RAM address
    a_addr_rng: assert property (@(posedge i_bclk) disable iff (!i_rst_n)
        (ram.we || ram.re) |-> ((ram.we ? rec_len_q : rd_ptr) < DEPTH));

    a_load_lat: assert property (@(posedge i_bclk) disable iff (!i_rst_n)
        ram.re |=> o_play_load);

endmodule

`default_nettype wire

//--- aud_ram_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "aud_config.svh"

interface aud_ram_if;

    logic                   we;     // write at the clock edge
    logic                   re;     // rdata valid one cycle later
    logic [`AUD_ADDR_W-1:0] addr;
    logic [`AUD_WORD_W-1:0] wdata;
    logic [`AUD_WORD_W-1:0] rdata;  // held until the next read

    modport ctrl (
        output we,
        output re,
        output addr,
        output wdata,
        input  rdata
    );

    modport mem (
        input  we,
        input  re,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

//--- aud_pkg.sv
`default_nettype none

package aud_pkg;

    // command opcodes on i_cmd
    typedef enum logic [1:0] {
        CMD_REC   = 2'd0,
        CMD_PLAY  = 2'd1,
        CMD_PAUSE = 2'd2,
        CMD_STOP  = 2'd3
    } aud_cmd_e;

    // engine mode
    typedef enum logic [1:0] {
        MODE_IDLE  = 2'd0,
        MODE_REC   = 2'd1,
        MODE_PLAY  = 2'd2,
        MODE_PAUSE = 2'd3
    } aud_mode_e;

endpackage

`default_nettype wire

//--- aud_config.svh
`ifndef AUD_CONFIG_SVH
`define AUD_CONFIG_SVH

// sample width in bits
`define AUD_WORD_W 16

// sample RAM address width, 64 words
`define AUD_ADDR_W 6

// bit clocks from a frame-clock edge to the MSB, I2S timing
`define AUD_DATA_DLY 1

`endif
